// File: src/i2c_macros.svh
`ifndef I2C_MACROS_SVH
`define I2C_MACROS_SVH

// ----------------------------------------
// Frame and word widths
// ----------------------------------------

// Start bit, 8 data bits, ack bit, stop bit
`define I2C_FRAME_W 11

// Bits sampled on SCL rises
`define I2C_RX_W 10

// Enough for any bit count up to 15
`define I2C_CNT_W 4

// ----------------------------------------
// Timing
// ----------------------------------------

// One SCL half period is 2**I2C_DIV_W clocks
`define I2C_DIV_W 10

// Stages on the SCL and SDA inputs
`define I2C_SYNC_DEPTH 2

// SDA waits this long so SCL is surely low first
`define I2C_SDA_HOLD 5

`endif

// File: src/i2c_pkg.sv
`include "i2c_macros.svh"

package i2c_pkg;

    // ----------------------------------------
    // Payload types
    // ----------------------------------------

    // Transmit frame as loaded from the caller
    typedef logic [`I2C_FRAME_W-1:0] frame_t;

    // Receive word with the oldest bit on top
    typedef logic [`I2C_RX_W-1:0] rx_word_t;

    // Number of SCL rises in the transfer phase
    typedef logic [`I2C_CNT_W-1:0] bit_cnt_t;

    // Both bus lines sampled together
    typedef struct packed {
        logic scl;
        logic sda;
    } line_pair_t;

    // One-hot frame sequence
    typedef enum logic [4:0] {
        IDLE  = 5'b00001,
        START = 5'b00010,
        TRANS = 5'b00100,
        STOP  = 5'b01000,
        DONE  = 5'b10000
    } i2c_state_e;

endpackage

// File: src/i2c_delay_line.sv
`timescale 1ns/100ps

// Fixed chain of registers for any packed payload
// Used as input synchronizer and as SDA hold delay
module i2c_delay_line #(
    parameter type T     = logic,
    parameter int  DEPTH = 2
) (
    input  logic clk,
    input  logic rst_i,
    input  T     d_i,
    output T     q_o
);

    // ----------------------------------------
    // Register chain
    // ----------------------------------------

    // Stage 0 takes the input
    T [DEPTH-1:0] stage_q;

    always_ff @(posedge clk or posedge rst_i) begin
        if (rst_i) begin
            // All ones is the released bus level
            stage_q <= '1;
        end else begin
            stage_q[0] <= d_i;
            // Each stage copies its predecessor
            for (int i = 1; i < DEPTH; i++) begin
                stage_q[i] <= stage_q[i-1];
            end
        end
    end

    // ----------------------------------------
    // Output
    // ----------------------------------------

    // Last stage gives exactly DEPTH cycles
    assign q_o = stage_q[DEPTH-1];

endmodule

// File: src/i2c_bit_ctrl.sv
`timescale 1ns/100ps

`include "i2c_macros.svh"

// Frame sequencer with SCL generation
module i2c_bit_ctrl import i2c_pkg::*; #(
    parameter int DIV_W = `I2C_DIV_W
) (
    input  logic       clk,
    input  logic       rst_i,
    input  logic       trans_trg_i,
    input  bit_cnt_t   trans_bit_num_i,
    input  logic       scl_sync_i,
    output i2c_state_e state_next_o,
    output logic       load_o,
    output logic       scl_fall_o,
    output logic       scl_rise_o,
    output logic       scl_oen_o,
    output logic       trans_done_o
);

    i2c_state_e        state_q;
    i2c_state_e        state_next;
    logic [DIV_W-1:0]  div_cnt_q;
    logic              div_carry_q;
    bit_cnt_t          bit_cnt_q;
    logic              scl_oen_q;
    logic              done_q;
    logic              scl_d2_q;
    logic              scl_d3_q;
    logic              scl_fall_q;
    logic              scl_rise_q;

    // Trigger only counts in idle
    assign load_o = trans_trg_i && (state_q == IDLE);

    // ----------------------------------------
    // State machine
    // ----------------------------------------

    always_ff @(posedge clk or posedge rst_i) begin
        if (rst_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_next;
        end
    end

    always_comb begin
        state_next = IDLE;
        unique case (state_q)
            IDLE: begin
                state_next = trans_trg_i ? START : IDLE;
            end
            // Start condition holds for one half period
            START: begin
                state_next = div_carry_q ? TRANS : START;
            end
            // Leave as soon as all rises are done
            TRANS: begin
                state_next = (bit_cnt_q == '0) ? STOP : TRANS;
            end
            STOP: begin
                state_next = div_carry_q ? DONE : STOP;
            end
            DONE: begin
                state_next = div_carry_q ? IDLE : DONE;
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    assign state_next_o = state_next;

    // ----------------------------------------
    // Half period divider
    // ----------------------------------------

    // Carry pulses once per 2**DIV_W clocks
    always_ff @(posedge clk or posedge rst_i) begin
        if (rst_i) begin
            {div_carry_q, div_cnt_q} <= '0;
        end else if (state_next == IDLE) begin
            {div_carry_q, div_cnt_q} <= '0;
        end else begin
            {div_carry_q, div_cnt_q} <= {1'b0, div_cnt_q} + 1'b1;
        end
    end

    // ----------------------------------------
    // Bit counter and SCL enable
    // ----------------------------------------

    // Counts down once per SCL rise
    always_ff @(posedge clk or posedge rst_i) begin
        if (rst_i) begin
            bit_cnt_q <= '0;
        end else if (load_o) begin
            bit_cnt_q <= trans_bit_num_i;
        end else if (div_carry_q && !scl_oen_q) begin
            bit_cnt_q <= bit_cnt_q - 1'b1;
        end
    end

    // SCL released in idle and done
    always_ff @(posedge clk or posedge rst_i) begin
        if (rst_i) begin
            scl_oen_q <= 1'b1;
        end else if (state_next == IDLE || state_next == DONE) begin
            scl_oen_q <= 1'b1;
        end else if (div_carry_q) begin
            scl_oen_q <= ~scl_oen_q;
        end
    end

    assign scl_oen_o = scl_oen_q;

    // ----------------------------------------
    // SCL edge detect
    // ----------------------------------------

    // Two more stages behind the synchronizer
    always_ff @(posedge clk or posedge rst_i) begin
        if (rst_i) begin
            scl_d2_q   <= 1'b1;
            scl_d3_q   <= 1'b1;
            scl_fall_q <= 1'b0;
            scl_rise_q <= 1'b0;
        end else begin
            scl_d2_q   <= scl_sync_i;
            scl_d3_q   <= scl_d2_q;
            scl_fall_q <= scl_d3_q & ~scl_d2_q;
            scl_rise_q <= scl_d2_q & ~scl_d3_q;
        end
    end

    assign scl_fall_o = scl_fall_q;
    assign scl_rise_o = scl_rise_q;

    // ----------------------------------------
    // Done flag
    // ----------------------------------------

    // Low from accepted trigger to end of done phase
    always_ff @(posedge clk or posedge rst_i) begin
        if (rst_i) begin
            done_q <= 1'b1;
        end else if (load_o) begin
            done_q <= 1'b0;
        end else if (state_q == DONE && div_carry_q) begin
            done_q <= 1'b1;
        end
    end

    assign trans_done_o = done_q;

endmodule

// File: src/i2c_tx_shifter.sv
`timescale 1ns/100ps

`include "i2c_macros.svh"

// Frame shift register driving the SDA enable
module i2c_tx_shifter import i2c_pkg::*; (
    input  logic       clk,
    input  logic       rst_i,
    input  logic       load_i,
    input  frame_t     trans_din_i,
    input  logic       scl_fall_i,
    input  i2c_state_e state_next_i,
    output logic       sda_oen_o
);

    frame_t frame_q;
    logic   sda_oen_q;

    // ----------------------------------------
    // Frame shift register
    // ----------------------------------------

    // Top bit is always the one on the line
    always_ff @(posedge clk or posedge rst_i) begin
        if (rst_i) begin
            frame_q <= '1;
        end else if (load_i) begin
            frame_q <= {trans_din_i[`I2C_FRAME_W-1],   // start bit
                        trans_din_i[`I2C_FRAME_W-2:2], // data bits
                        trans_din_i[1],                // ack bit
                        trans_din_i[0]};               // stop bit
        end else if (scl_fall_i) begin
            // Next bit moves up while SCL is low
            frame_q <= {frame_q[`I2C_FRAME_W-2:0], 1'b0};
        end
    end

    // ----------------------------------------
    // SDA enable select
    // ----------------------------------------

    always_ff @(posedge clk or posedge rst_i) begin
        if (rst_i) begin
            sda_oen_q <= 1'b1;
        end else begin
            unique case (state_next_i)
                START, TRANS, STOP: begin
                    sda_oen_q <= frame_q[`I2C_FRAME_W-1];
                end
                // Line released outside a frame
                default: begin
                    sda_oen_q <= 1'b1;
                end
            endcase
        end
    end

    assign sda_oen_o = sda_oen_q;

endmodule

// File: src/i2c_rx_shifter.sv
`timescale 1ns/100ps

`include "i2c_macros.svh"

// Receive shift register fed from the synchronized SDA
module i2c_rx_shifter import i2c_pkg::*; (
    input  logic     clk,
    input  logic     load_i,
    input  logic     scl_rise_i,
    input  logic     sda_sync_i,
    output rx_word_t rx_word_o
);

    // ----------------------------------------
    // Shift register
    // ----------------------------------------

    rx_word_t rx_word_q;

    // Cleared at every accepted trigger
    // Newest sample enters at bit 0
    always_ff @(posedge clk) begin
        if (load_i) begin
            rx_word_q <= '0;
        end else if (scl_rise_i) begin
            rx_word_q <= {rx_word_q[`I2C_RX_W-2:0], sda_sync_i};
        end
    end

    // Oldest of the last samples sits on top
    assign rx_word_o = rx_word_q;

endmodule

// File: src/mt9v034_i2c_if.sv
`timescale 1ns/100ps

`include "i2c_macros.svh"

// Two-wire control port engine for the camera sensor
module mt9v034_i2c_if import i2c_pkg::*; #(
    parameter int DIV_W = `I2C_DIV_W
) (
    input  logic     clk,
    input  logic     rst_i,
    input  logic     trans_trg_i,
    input  bit_cnt_t trans_bit_num_i,
    input  frame_t   trans_din_i,
    output rx_word_t trans_dout_o,
    output logic     trans_done_o,
    output logic     scl_oen_o,
    input  logic     scl_i,
    output logic     sda_oen_o,
    input  logic     sda_i
);

    line_pair_t line_raw;
    line_pair_t line_sync;
    i2c_state_e state_next;
    logic       load;
    logic       scl_fall;
    logic       scl_rise;
    logic       sda_oen_raw;

    // ----------------------------------------
    // Input synchronizer
    // ----------------------------------------

    assign line_raw = '{scl: scl_i, sda: sda_i};

    i2c_delay_line #(
        .T     (line_pair_t),
        .DEPTH (`I2C_SYNC_DEPTH)
    ) u_line_sync (
        .clk   (clk),
        .rst_i (rst_i),
        .d_i   (line_raw),
        .q_o   (line_sync)
    );

    // ----------------------------------------
    // Sequencer
    // ----------------------------------------

    i2c_bit_ctrl #(
        .DIV_W (DIV_W)
    ) u_bit_ctrl (
        .clk             (clk),
        .rst_i           (rst_i),
        .trans_trg_i     (trans_trg_i),
        .trans_bit_num_i (trans_bit_num_i),
        .scl_sync_i      (line_sync.scl),
        .state_next_o    (state_next),
        .load_o          (load),
        .scl_fall_o      (scl_fall),
        .scl_rise_o      (scl_rise),
        .scl_oen_o       (scl_oen_o),
        .trans_done_o    (trans_done_o)
    );

    // ----------------------------------------
    // Transmit and receive paths
    // ----------------------------------------

    i2c_tx_shifter u_tx_shifter (
        .clk          (clk),
        .rst_i        (rst_i),
        .load_i       (load),
        .trans_din_i  (trans_din_i),
        .scl_fall_i   (scl_fall),
        .state_next_i (state_next),
        .sda_oen_o    (sda_oen_raw)
    );

    // Keeps SDA steady until SCL is well low
    i2c_delay_line #(
        .T     (logic),
        .DEPTH (`I2C_SDA_HOLD)
    ) u_sda_hold (
        .clk   (clk),
        .rst_i (rst_i),
        .d_i   (sda_oen_raw),
        .q_o   (sda_oen_o)
    );

    i2c_rx_shifter u_rx_shifter (
        .clk        (clk),
        .load_i     (load),
        .scl_rise_i (scl_rise),
        .sda_sync_i (line_sync.sda),
        .rx_word_o  (trans_dout_o)
    );

endmodule

// File: verification/tb_i2c_if.sv
`timescale 1ns/100ps

`include "i2c_macros.svh"

module tb_i2c_if import i2c_pkg::*; ();

    localparam int          DIV_W     = 4;
    localparam int          HALF      = 2 ** DIV_W;
    localparam int          NUM_TESTS = 5;
    localparam int          LIMIT     = NUM_TESTS * (`I2C_FRAME_W + 4) * 2 * HALF * 2;
    localparam logic [31:0] SEED      = 32'h91c4_d17f;

    logic     clk = 1'b0;
    logic     rst_i;
    logic     trans_trg_i;
    bit_cnt_t trans_bit_num_i;
    frame_t   trans_din_i;
    rx_word_t trans_dout_o;
    logic     trans_done_o;
    logic     scl_oen_o;
    logic     sda_oen_o;
    logic     scl_line;
    logic     sda_line;

    // Slave side state
    logic        slave_pull;
    logic [15:0] drive_mask;
    logic [3:0]  fall_idx;
    logic        scl_prev;
    logic        sda_prev;
    logic        rise_levels [$];
    int          start_cnt;
    int          stop_cnt;
    int          rise_cnt;

    int errors    = 0;
    int checks    = 0;
    int tests_run = 0;
    int cycle_cnt = 0;

    always #4 clk = ~clk;

    // Open drain with pull-ups so a released enable reads high
    assign scl_line = scl_oen_o;
    assign sda_line = sda_oen_o & ~slave_pull;

    mt9v034_i2c_if #(
        .DIV_W (DIV_W)
    ) i_dut (
        .clk             (clk),
        .rst_i           (rst_i),
        .trans_trg_i     (trans_trg_i),
        .trans_bit_num_i (trans_bit_num_i),
        .trans_din_i     (trans_din_i),
        .trans_dout_o    (trans_dout_o),
        .trans_done_o    (trans_done_o),
        .scl_oen_o       (scl_oen_o),
        .scl_i           (scl_line),
        .sda_oen_o       (sda_oen_o),
        .sda_i           (sda_line)
    );

    // ----------------------------------------
    // Bus monitor and slave model
    // ----------------------------------------

    // Sampled like a flop since lines only move at clock edges
    always @(posedge clk or posedge rst_i) begin
        if (rst_i) begin
            slave_pull <= 1'b0;
            fall_idx   = '0;
            scl_prev   = 1'b1;
            sda_prev   = 1'b1;
            start_cnt  = 0;
            stop_cnt   = 0;
            rise_cnt   = 0;
        end else begin
            if (scl_line && scl_prev && sda_prev && !sda_line) begin
                // Start opens a new frame record
                start_cnt++;
                fall_idx = '0;
                rise_levels.delete();
                slave_pull <= 1'b0;
            end
            if (scl_line && scl_prev && !sda_prev && sda_line) begin
                stop_cnt++;
            end
            if (scl_line && !scl_prev) begin
                rise_cnt++;
                rise_levels.push_back(sda_line);
            end
            if (!scl_line && scl_prev) begin
                // Slot k runs from fall k to fall k+1
                fall_idx = fall_idx + 4'd1;
                slave_pull <= drive_mask[fall_idx];
            end
            scl_prev = scl_line;
            sda_prev = sda_line;
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= LIMIT) begin
            $display("Timeout after %0d cycles, a frame never completed", LIMIT);
            $display("Finished with errors");
            $finish;
        end
    end

    // ----------------------------------------
    // Helpers
    // ----------------------------------------

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_event(input logic ok, input string what);
        checks++;
        assert (ok) else begin
            $display("Error: %s", what);
            errors++;
        end
    endtask

    function automatic logic bit_at(input logic [15:0] v, input int k);
        logic [15:0] s;
        s = v >> k;
        return s[0];
    endfunction

    // Start bit and last bit on the line both low so start and stop show
    function automatic frame_t make_frame(input bit_cnt_t n);
        frame_t f;
        f = frame_t'($urandom);
        f[`I2C_FRAME_W-1] = 1'b0;
        f = f & ~(frame_t'(1) << (`I2C_FRAME_W - 1 - int'(n)));
        return f;
    endfunction

    // Strobe one frame and optionally a second strobe while busy
    task automatic run_frame(input frame_t frame, input bit_cnt_t n,
                             input int extra_at, output int latency);
        int cyc;
        @(posedge clk);
        trans_din_i     <= frame;
        trans_bit_num_i <= n;
        trans_trg_i     <= 1'b1;
        @(posedge clk);
        trans_trg_i <= 1'b0;
        trans_din_i <= '0;
        @(negedge clk);
        check_value("trans_done_o", 32'(trans_done_o), 32'd0);
        cyc = 1;
        while (trans_done_o !== 1'b1) begin
            @(posedge clk);
            if (cyc == extra_at) begin
                trans_din_i     <= ~frame;
                trans_bit_num_i <= n - 4'd2;
                trans_trg_i     <= 1'b1;
            end else begin
                trans_trg_i <= 1'b0;
            end
            @(negedge clk);
            cyc++;
        end
        latency = cyc;
    endtask

    // Line levels follow frame bits 9 downward minus slave pulls
    task automatic check_frame(input frame_t frame, input bit_cnt_t n,
                               input logic [15:0] mask, input int s0, input int p0);
        rx_word_t exp_word;
        logic     exp_lvl;
        exp_word = '0;
        check_event(start_cnt == s0 + 1, "No single start condition seen on the bus");
        check_event(stop_cnt == p0 + 1, "No single stop condition seen on the bus");
        check_value("rise_levels.size", 32'(rise_levels.size()), 32'(n));
        for (int k = 1; k <= int'(n); k++) begin
            exp_lvl = bit_at(16'(frame), `I2C_FRAME_W - 1 - k) & ~bit_at(mask, k);
            // Newest level lands in bit 0 of the receive word
            if (int'(n) - k < `I2C_RX_W) begin
                exp_word[int'(n) - k] = exp_lvl;
            end
            if (k <= rise_levels.size()) begin
                check_value($sformatf("sda_line rise %0d", k), 32'(rise_levels[k-1]),
                            32'(exp_lvl));
            end
        end
        check_value("trans_dout_o", 32'(trans_dout_o), 32'(exp_word));
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        $display("Test %s: %s", name, (errors == errs_before) ? "passed" : "FAILED");
    endtask

    // ----------------------------------------
    // Directed tests
    // ----------------------------------------

    initial begin
        int          errs;
        int          lat;
        int          lat_ref;
        int          prev_rises;
        int          s0;
        int          p0;
        int          r0;
        bit_cnt_t    n;
        frame_t      frame;
        logic [15:0] mask;

        rst_i           <= 1'b1;
        trans_trg_i     <= 1'b0;
        trans_bit_num_i <= '0;
        trans_din_i     <= '0;
        drive_mask = '0;
        void'($urandom(SEED));
        repeat (8) @(posedge clk);
        rst_i <= 1'b0;
        @(negedge clk);

        // Idle lines after reset
        errs = errors;
        s0 = start_cnt;
        r0 = rise_cnt;
        repeat (3 * HALF) begin
            @(negedge clk);
            check_value("trans_done_o", 32'(trans_done_o), 32'd1);
            check_value("scl_oen_o", 32'(scl_oen_o), 32'd1);
            check_value("sda_oen_o", 32'(sda_oen_o), 32'd1);
        end
        check_event(start_cnt == s0 && rise_cnt == r0, "Bus activity without a trigger");
        report_test("reset_idle", errs);

        errs = errors;
        n = 4'd9;
        frame = make_frame(n);
        s0 = start_cnt;
        p0 = stop_cnt;
        run_frame(frame, n, -1, lat);
        check_frame(frame, n, '0, s0, p0);
        report_test("frame_tx", errs);

        // Slave pulls odd slots where the frame bit is 1
        errs = errors;
        frame = make_frame(n) | frame_t'(11'h200);
        mask = '0;
        for (int k = 1; k < int'(n); k += 2) begin
            if (bit_at(16'(frame), `I2C_FRAME_W - 1 - k)) begin
                mask = mask | (16'(1) << k);
            end
        end
        drive_mask = mask;
        s0 = start_cnt;
        p0 = stop_cnt;
        run_frame(frame, n, -1, lat);
        check_frame(frame, n, mask, s0, p0);
        drive_mask = '0;
        report_test("rx_slave_drive", errs);

        // Same frame with and without a strobe mid-frame
        errs = errors;
        frame = make_frame(n);
        run_frame(frame, n, -1, lat_ref);
        s0 = start_cnt;
        p0 = stop_cnt;
        run_frame(frame, n, 6 * HALF, lat);
        check_frame(frame, n, '0, s0, p0);
        check_value("done latency", 32'(lat), 32'(lat_ref));
        report_test("busy_trigger", errs);

        errs = errors;
        prev_rises = 0;
        for (int k = 0; k < 3; k++) begin
            n = bit_cnt_t'(3 + 3 * k);
            frame = make_frame(n);
            s0 = start_cnt;
            p0 = stop_cnt;
            run_frame(frame, n, -1, lat);
            check_frame(frame, n, '0, s0, p0);
            check_event(rise_levels.size() > prev_rises, "Rise count did not grow");
            prev_rises = rise_levels.size();
        end
        report_test("back_to_back", errs);

        $display("Tests: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: vlog.f
+incdir+src
src/i2c_pkg.sv
src/i2c_delay_line.sv
src/i2c_bit_ctrl.sv
src/i2c_tx_shifter.sv
src/i2c_rx_shifter.sv
src/mt9v034_i2c_if.sv
verification/tb_i2c_if.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f vlog.f \
    --top-module tb_i2c_if \
    -Mdir obj_dir \
    -o sim_tb_i2c_if

output="$(./obj_dir/sim_tb_i2c_if)"
echo "$output"

if echo "$output" | grep -qx "Finished with no errors"; then
    exit 0
else
    exit 1
fi
